//--- Makefile
# Verilator flow for the vector unit testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_vec_top with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
	  --top-module tb_vec_top -Mdir obj_dir -o tb_vec_top -f sources.f
	@out="$$(./obj_dir/tb_vec_top)"; echo "$$out"; \
	  echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf obj_dir

//--- sources.f
+incdir+.
vec_pkg.sv
vec_dispatcher.sv
vec_lane.sv
vec_result.sv
vec_top.sv
tb_vec_top.sv

//--- tb_vec_top.sv
/*
 * Testbench for the vector unit: clock, reset, LCG stimulus,
 * register file reference model, checks and watchdog
 */

`timescale 1ns/1ns

`include "vec_consts.svh"

module tb_vec_top;

  localparam int unsigned NrElems      = `VEC_VLEN / `VEC_ELEN;
  localparam int unsigned ElemsPerLane = `VEC_VLEN / (`VEC_ELEN * `VEC_NR_LANES);
  localparam int unsigned IdleLatency  = ElemsPerLane + 2;
  localparam int unsigned NrRand       = 20;
  // Directed requests, the register setup and the random op/reduction pairs
  localparam int unsigned NrReqs       = 5 + `VEC_NR_VREGS + 2 * NrRand;
  localparam int unsigned TimeoutCyc   = NrReqs * 20;

  logic               clk_i;
  logic               rst_i;
  logic               req_valid_i;
  logic               req_ready_o;
  vec_pkg::vec_req_t  req_i;
  logic               resp_valid_o;
  vec_pkg::vec_resp_t resp_o;

  vec_pkg::elem_t     model_vrf [`VEC_NR_VREGS][NrElems];
  vec_pkg::vec_resp_t exp_q [$];
  int unsigned        accept_cyc_q [$];
  vec_pkg::vec_resp_t last_resp;
  int unsigned        last_latency;
  int unsigned        cycle = 0;
  int unsigned        accepted = 0;
  int unsigned        responses = 0;
  int unsigned        stall_cnt = 0;
  int unsigned        value_errs = 0;
  int unsigned        other_errs = 0;
  logic [31:0]        lcg_state = 32'hb85f_eab7;
  string              test_name = "reset";

  vec_top dut_i (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .req_i       (req_i       ),
    .resp_valid_o(resp_valid_o),
    .resp_o      (resp_o      )
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic vec_pkg::vec_req_t make_req(input vec_pkg::vec_op_e op,
                                                 input vec_pkg::vreg_idx_t vd,
                                                 input vec_pkg::vreg_idx_t vs1,
                                                 input vec_pkg::vreg_idx_t vs2,
                                                 input vec_pkg::elem_t scalar);
    return '{op: op, vd: vd, vs1: vs1, vs2: vs2, scalar: scalar};
  endfunction

  // Updates the model registers and returns the response data
  function automatic vec_pkg::elem_t model_apply(input vec_pkg::vec_req_t r);
    vec_pkg::elem_t a;
    vec_pkg::elem_t b;
    vec_pkg::elem_t res;
    vec_pkg::elem_t sum;
    sum = '0;
    for (int i = 0; i < NrElems; i++) begin
      a   = model_vrf[r.vs1][i];
      b   = model_vrf[r.vs2][i];
      sum = sum + b;
      case (r.op)
        vec_pkg::OP_VADD:  res = b + a;
        vec_pkg::OP_VSUB:  res = b - a;
        vec_pkg::OP_VAND:  res = b & a;
        vec_pkg::OP_VOR:   res = b | a;
        vec_pkg::OP_VXOR:  res = b ^ a;
        vec_pkg::OP_VMVVX: res = r.scalar;
        vec_pkg::OP_VID:   res = vec_pkg::elem_t'(i) + r.scalar;
        default:           res = b;
      endcase
      if (r.op != vec_pkg::OP_VREDSUM) begin
        model_vrf[r.vd][i] = res;
      end
    end
    return (r.op == vec_pkg::OP_VREDSUM) ? sum : '0;
  endfunction

  task automatic check_eq(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
    assert (expected == actual) else begin
      value_errs++;
      $display("CHECK FAILED %s/%s: expected %0h, actual %0h",
               test_name, what, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond) else begin
      other_errs++;
      $display("Error in %s: %s", test_name, msg);
    end
  endtask

  // Called 5 ns after a rising edge, returns 5 ns after the transfer edge
  task automatic send_req(input vec_pkg::vec_req_t r);
    req_i       = r;
    req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #5;
  endtask

  task automatic wait_idle();
    do @(posedge clk_i); while (exp_q.size() != 0);
    #5;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor sampled at the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    vec_pkg::vec_resp_t exp_resp;
    if (!rst_i) begin
      // Responses before requests
      // A request accepted now cannot answer yet
      if (resp_valid_o) begin
        responses++;
        last_resp = resp_o;
        if (exp_q.size() == 0) begin
          check_true(1'b0, "response arrived with no request outstanding");
        end else begin
          exp_resp     = exp_q.pop_front();
          last_latency = cycle - accept_cyc_q.pop_front();
          check_eq("resp_op", 32'(exp_resp.op), 32'(resp_o.op));
          check_eq("resp_data", exp_resp.data, resp_o.data);
        end
      end
      if (req_valid_i && !req_ready_o) begin
        stall_cnt++;
      end
      if (req_valid_i && req_ready_o) begin
        accepted++;
        exp_resp.op   = req_i.op;
        exp_resp.data = model_apply(req_i);
        exp_q.push_back(exp_resp);
        accept_cyc_q.push_back(cycle);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    vec_pkg::elem_t     s;
    vec_pkg::vreg_idx_t vd;
    vec_pkg::vec_op_e   op;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    for (int r = 0; r < `VEC_NR_VREGS; r++) begin
      for (int i = 0; i < NrElems; i++) begin
        model_vrf[r][i] = '0;
      end
    end
    repeat (2) @(posedge clk_i);
    #5;
    rst_i = 1'b0;

    @(negedge clk_i);
    check_true(req_ready_o, "req_ready_o low after reset");
    check_true(!resp_valid_o, "resp_valid_o high after reset");
    @(posedge clk_i);
    #5;

    // Broadcast then reduce gives eight copies of the scalar
    test_name = "broadcast";
    s = lcg_next();
    send_req(make_req(vec_pkg::OP_VMVVX, 3'd3, 3'd0, 3'd0, s));
    send_req(make_req(vec_pkg::OP_VREDSUM, 3'd0, 3'd0, 3'd3, '0));
    req_valid_i = 1'b0;
    wait_idle();
    check_eq("sum", s * NrElems, last_resp.data);

    // Index sequence adds 0 to 7 on top of the scalar
    test_name = "index";
    s = lcg_next() >> 4;
    send_req(make_req(vec_pkg::OP_VID, 3'd4, 3'd0, 3'd0, s));
    send_req(make_req(vec_pkg::OP_VREDSUM, 3'd0, 3'd0, 3'd4, '0));
    req_valid_i = 1'b0;
    wait_idle();
    check_eq("sum", s * NrElems + NrElems * (NrElems - 1) / 2, last_resp.data);

    test_name = "latency";
    send_req(make_req(vec_pkg::OP_VREDSUM, 3'd0, 3'd0, 3'd3, '0));
    req_valid_i = 1'b0;
    wait_idle();
    check_eq("cycles", IdleLatency, last_latency);

    // Back-to-back random traffic on registers seeded with index sequences
    test_name = "random";
    stall_cnt = 0;
    for (int r = 0; r < `VEC_NR_VREGS; r++) begin
      send_req(make_req(vec_pkg::OP_VID, 3'(r), 3'd0, 3'd0, lcg_next() >> 8));
    end
    for (int n = 0; n < NrRand; n++) begin
      op = vec_pkg::vec_op_e'(3'((lcg_next() >> 16) % 32'd5));
      vd = 3'(lcg_next() >> 20);
      send_req(make_req(op, vd, 3'(lcg_next() >> 20), 3'(lcg_next() >> 20), '0));
      send_req(make_req(vec_pkg::OP_VREDSUM, 3'd0, 3'd0, vd, '0));
    end
    req_valid_i = 1'b0;
    wait_idle();
    check_true(stall_cnt > 0, "req_ready_o never dropped during the burst");
    check_true(accepted == responses, "response count differs from accepted requests");

    $display("Errors: %0d value, %0d other, %0d of %0d responses received",
             value_errs, other_errs, responses, accepted);
    if (value_errs + other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TimeoutCyc) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", TimeoutCyc);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule : tb_vec_top

//--- vec_consts.svh
/*
 * Vector unit sizing macros: lane count, register length, element width
 * and vector register count
 */

`ifndef VEC_CONSTS_SVH
`define VEC_CONSTS_SVH

// Lanes in the default build
`define VEC_NR_LANES 4

// Vector register length in bits
`define VEC_VLEN 256

// Element width in bits
`define VEC_ELEN 32

// Architectural vector registers
`define VEC_NR_VREGS 8

`endif

//--- vec_dispatcher.sv
/*
 * Decode stage: host request handshake, opcode decode and
 * a single holding register issuing to all lanes
 */

`timescale 1ns/1ns

module vec_dispatcher #(
    parameter int unsigned NrLanes = 1
  ) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    // Host request channel
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  vec_pkg::vec_req_t     req_i,
    // Issue to the lanes
    output logic                  issue_valid_o,
    output vec_pkg::lane_issue_t  issue_o,
    input  logic    [NrLanes-1:0] lanes_ready_i,
    output logic                  issue_fire_o,
    // Op handed to the result unit
    output vec_pkg::vec_op_e      issue_op_o
  );

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  vec_pkg::lane_issue_t req_dec;
  vec_pkg::lane_issue_t hold_q;
  logic                 hold_valid_q;
  logic                 req_fire;

  always_comb begin
    req_dec.op     = req_i.op;
    req_dec.vd     = req_i.vd;
    req_dec.vs1    = req_i.vs1;
    req_dec.vs2    = req_i.vs2;
    req_dec.scalar = req_i.scalar;
    // Reduction only produces a scalar
    req_dec.writes_vd = (req_i.op != vec_pkg::OP_VREDSUM);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Holding register
  ////////////////////////////////////////////////////////////////////////////

  // Every lane must take the instruction in the same cycle
  assign issue_fire_o = hold_valid_q & (&lanes_ready_i);
  assign req_ready_o  = ~hold_valid_q | issue_fire_o;
  assign req_fire     = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hold_valid_q <= 1'b0;
      hold_q       <= '0;
    end else begin
      if (req_fire) begin
        hold_valid_q <= 1'b1;
        hold_q       <= req_dec;
      end else if (issue_fire_o) begin
        hold_valid_q <= 1'b0;
      end
    end
  end

  assign issue_valid_o = hold_valid_q;
  assign issue_o       = hold_q;
  assign issue_op_o    = hold_q.op;

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Stalled issue keeps its payload until all lanes take it
  a_issue_stable : assert property (
    @(posedge clk_i) disable iff (rst_i)
    issue_valid_o && !issue_fire_o |=> issue_valid_o && $stable(issue_o)
  );

endmodule : vec_dispatcher

//--- vec_lane.sv
/*
 * Execute stage: one lane with its vector register slice,
 * element sequencer, integer ALU and partial sum
 */

`timescale 1ns/1ns

`include "vec_consts.svh"

module vec_lane #(
    parameter int unsigned NrLanes = `VEC_NR_LANES,
    parameter int unsigned LaneId  = 0
  ) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    // Issue from the dispatcher
    input  logic                 issue_valid_i,
    input  vec_pkg::lane_issue_t issue_i,
    output logic                 ready_o,
    // Completion towards the result unit
    output logic                 done_o,
    output vec_pkg::elem_t       sum_o
  );

  localparam int unsigned ElemsPerLane = `VEC_VLEN / (`VEC_ELEN * NrLanes);
  localparam int unsigned CntW         = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1;

  vec_pkg::lane_state_e state_q;
  vec_pkg::lane_issue_t insn_q;
  logic [CntW-1:0]      cnt_q;
  logic                 last_elem;
  vec_pkg::elem_t       sum_q;

  // Element k of the slice is global element k*NrLanes + LaneId
  vec_pkg::elem_t       vrf_q [`VEC_NR_VREGS][ElemsPerLane];

  vec_pkg::elem_t       op_a;
  vec_pkg::elem_t       op_b;
  vec_pkg::elem_t       elem_idx;
  vec_pkg::elem_t       alu_res;
  logic                 vrf_we;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  assign ready_o   = (state_q == vec_pkg::LANE_IDLE);
  assign last_elem = (cnt_q == CntW'(ElemsPerLane - 1));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= vec_pkg::LANE_IDLE;
      insn_q  <= '0;
      cnt_q   <= '0;
      sum_q   <= '0;
    end else begin
      case (state_q)
        vec_pkg::LANE_IDLE: begin
          if (issue_valid_i) begin
            state_q <= vec_pkg::LANE_BUSY;
            insn_q  <= issue_i;
            cnt_q   <= '0;
            sum_q   <= '0;
          end
        end
        vec_pkg::LANE_BUSY: begin
          sum_q <= sum_o;
          cnt_q <= cnt_q + 1'b1;
          if (last_elem) begin
            state_q          <= vec_pkg::LANE_IDLE;
            // Write flag retires with the instruction
            insn_q.writes_vd <= 1'b0;
          end
        end
        default: state_q <= vec_pkg::LANE_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  assign op_a     = vrf_q[insn_q.vs1][cnt_q];
  assign op_b     = vrf_q[insn_q.vs2][cnt_q];
  assign elem_idx = vec_pkg::elem_t'(cnt_q) * vec_pkg::elem_t'(NrLanes)
                  + vec_pkg::elem_t'(LaneId);

  always_comb begin
    case (insn_q.op)
      // vd = vs2 - vs1
      vec_pkg::OP_VSUB:  alu_res = op_b - op_a;
      vec_pkg::OP_VAND:  alu_res = op_b & op_a;
      vec_pkg::OP_VOR:   alu_res = op_b | op_a;
      vec_pkg::OP_VXOR:  alu_res = op_b ^ op_a;
      vec_pkg::OP_VMVVX: alu_res = insn_q.scalar;
      vec_pkg::OP_VID:   alu_res = elem_idx + insn_q.scalar;
      default:           alu_res = op_b + op_a;
    endcase
  end

  assign vrf_we = insn_q.writes_vd;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vrf_q <= '{default: '0};
    end else if (vrf_we) begin
      vrf_q[insn_q.vd][cnt_q] <= alu_res;
    end
  end

  // Partial sum of vs2 is complete in the last busy cycle
  assign sum_o  = sum_q + op_b;
  assign done_o = (state_q == vec_pkg::LANE_BUSY) & last_elem;

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Register slice only changes while an instruction runs
  a_no_idle_write : assert property (
    @(posedge clk_i) disable iff (rst_i)
    vrf_we |-> state_q == vec_pkg::LANE_BUSY
  );

  // Done is a single pulse that ends the busy phase
  a_done_pulse : assert property (
    @(posedge clk_i) disable iff (rst_i)
    done_o |-> state_q == vec_pkg::LANE_BUSY ##1 (state_q == vec_pkg::LANE_IDLE && !done_o)
  );

endmodule : vec_lane

//--- vec_pkg.sv
/*
 * Vector unit types: opcodes, lane sequencer states,
 * host request, lane issue and response structs
 */

`include "vec_consts.svh"

package vec_pkg;

  // Integer vector opcodes
  typedef enum logic [2:0] {
    OP_VADD    = 3'd0,
    OP_VSUB    = 3'd1,
    OP_VAND    = 3'd2,
    OP_VOR     = 3'd3,
    OP_VXOR    = 3'd4,
    OP_VMVVX   = 3'd5,  // broadcast scalar into vd
    OP_VID     = 3'd6,  // element index plus scalar
    OP_VREDSUM = 3'd7
  } vec_op_e;

  typedef logic [$clog2(`VEC_NR_VREGS)-1:0] vreg_idx_t;
  typedef logic [`VEC_ELEN-1:0]             elem_t;

  // Host request
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } vec_req_t;

  // Decoded instruction broadcast to every lane
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    logic      writes_vd;
  } lane_issue_t;

  typedef struct packed {
    vec_op_e op;
    elem_t   data;
  } vec_resp_t;

  typedef enum logic {
    LANE_IDLE = 1'b0,
    LANE_BUSY = 1'b1
  } lane_state_e;

endpackage : vec_pkg

//--- vec_result.sv
/*
 * Result stage: in-order op queue, lane completion join,
 * partial sum reduction and response register
 */

`timescale 1ns/1ns

module vec_result #(
    parameter int unsigned NrLanes = 1
  ) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    // From the dispatcher
    input  logic                                issue_fire_i,
    input  vec_pkg::vec_op_e                    issue_op_i,
    // From the lanes
    input  logic                  [NrLanes-1:0] lane_done_i,
    input  vec_pkg::elem_t        [NrLanes-1:0] lane_sum_i,
    // Host response
    output logic                                resp_valid_o,
    output vec_pkg::vec_resp_t                  resp_o
  );

  vec_pkg::vec_op_e   op_q [2];
  logic [1:0]         q_cnt_q;
  logic               all_done;
  vec_pkg::elem_t     acc_next;

  ////////////////////////////////////////////////////////////////////////////
  // Completion join
  ////////////////////////////////////////////////////////////////////////////

  // Lanes run in lock step and report done in the same cycle
  always_comb begin
    all_done = &lane_done_i;
    acc_next = '0;
    for (int i = 0; i < NrLanes; i++) begin
      acc_next = acc_next + lane_sum_i[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_o <= 1'b0;
      resp_o       <= '0;
    end else begin
      resp_valid_o <= all_done;
      if (all_done) begin
        resp_o.op   <= op_q[0];
        resp_o.data <= (op_q[0] == vec_pkg::OP_VREDSUM) ? acc_next : '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Op queue with the oldest entry at index 0
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      q_cnt_q <= '0;
      op_q[0] <= vec_pkg::OP_VADD;
      op_q[1] <= vec_pkg::OP_VADD;
    end else begin
      case ({issue_fire_i, all_done})
        2'b10: begin
          op_q[q_cnt_q[0]] <= issue_op_i;
          q_cnt_q          <= q_cnt_q + 2'd1;
        end
        2'b01: begin
          op_q[0] <= op_q[1];
          q_cnt_q <= q_cnt_q - 2'd1;
        end
        2'b11: begin
          op_q[0] <= (q_cnt_q == 2'd1) ? issue_op_i : op_q[1];
          op_q[1] <= issue_op_i;
        end
        default: begin
          q_cnt_q <= q_cnt_q;
        end
      endcase
    end
  end

  // A lane can only finish an instruction that was issued
  a_done_has_op : assert property (
    @(posedge clk_i) disable iff (rst_i)
    |lane_done_i |-> q_cnt_q != 2'd0
  );

endmodule : vec_result

//--- vec_top.sv
/*
 * Vector unit top level: dispatcher, lane array and result unit
 */

`timescale 1ns/1ns

`include "vec_consts.svh"

module vec_top #(
    parameter int unsigned NrLanes = `VEC_NR_LANES
  ) (
    input  logic               clk_i,
    input  logic               rst_i,
    // Host request channel
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  vec_pkg::vec_req_t  req_i,
    // Host response, no back-pressure
    output logic               resp_valid_o,
    output vec_pkg::vec_resp_t resp_o
  );

  ////////////////////////////////////////////////////////////////////////////
  // Dispatcher
  ////////////////////////////////////////////////////////////////////////////

  logic                                issue_valid;
  logic                                issue_fire;
  vec_pkg::lane_issue_t                issue;
  vec_pkg::vec_op_e                    issue_op;
  logic                  [NrLanes-1:0] lane_ready;
  logic                  [NrLanes-1:0] lane_done;
  vec_pkg::elem_t        [NrLanes-1:0] lane_sum;

  vec_dispatcher #(
    .NrLanes(NrLanes)
  ) i_dispatcher (
    .clk_i        (clk_i      ),
    .rst_i        (rst_i      ),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i      ),
    .issue_valid_o(issue_valid),
    .issue_o      (issue      ),
    .lanes_ready_i(lane_ready ),
    .issue_fire_o (issue_fire ),
    .issue_op_o   (issue_op   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .NrLanes(NrLanes),
      .LaneId (l      )
    ) i_lane (
      .clk_i        (clk_i        ),
      .rst_i        (rst_i        ),
      .issue_valid_i(issue_valid  ),
      .issue_i      (issue        ),
      .ready_o      (lane_ready[l]),
      .done_o       (lane_done[l] ),
      .sum_o        (lane_sum[l]  )
    );
  end : gen_lanes

  ////////////////////////////////////////////////////////////////////////////
  // Result unit
  ////////////////////////////////////////////////////////////////////////////

  vec_result #(
    .NrLanes(NrLanes)
  ) i_result (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .issue_fire_i(issue_fire  ),
    .issue_op_i  (issue_op    ),
    .lane_done_i (lane_done   ),
    .lane_sum_i  (lane_sum    ),
    .resp_valid_o(resp_valid_o),
    .resp_o      (resp_o      )
  );

  // Elaboration checks
  if (NrLanes == 0) begin : gen_chk_zero
    $error("vec_top needs at least one lane");
  end

  if (NrLanes != 2**$clog2(NrLanes)) begin : gen_chk_pow2
    $error("vec_top lane count must be a power of two");
  end

  if (`VEC_VLEN % (`VEC_ELEN * NrLanes) != 0) begin : gen_chk_split
    $error("vec_top register length does not split evenly over the lanes");
  end

endmodule : vec_top
